//--- logic/engine_ctrl_pkg.sv
/* register map, field widths and shared types for the engine control block
   every design file refers to these by scoped name */
package engine_ctrl_pkg;

   localparam int DATA_WIDTH = 32;
   localparam int SEL_WIDTH = 4;
   localparam int ADDR_WIDTH = 6; // word address

   localparam int BOARD_WIDTH = 256;
   localparam int BOARD_WORDS = 8;
   localparam int MOVE_INDEX_WIDTH = 8;
   localparam int HALF_MOVE_WIDTH = 7;
   localparam int EVAL_WIDTH = 24;
   localparam int DEPTH_WIDTH = 8;
   localparam int NODES_WIDTH = 28;

   // command word bits
   localparam int CMD_NEW_BOARD_BIT = 0;
   localparam int CMD_CLEAR_MOVES_BIT = 1;
   localparam int CMD_SOFT_RESET_BIT = 31;

   localparam int POS_CASTLE_LSB = 4; // en-passant column sits below
   localparam int POS_WHITE_BIT = 8;

   localparam int ENTRY_FLAG_LSB = 28; // high entry word
   localparam int ENTRY_CAPTURE_BIT = 31;

   // table command bits
   localparam int TT_LOOKUP_BIT = 0;
   localparam int TT_STORE_BIT = 1;
   localparam int TT_HASH_ONLY_BIT = 2;
   localparam int TT_CLEAR_BIT = 3;

   typedef enum logic [ADDR_WIDTH-1:0] {
      REG_CMD = 6'd0,
      REG_MOVE_INDEX = 6'd1,
      REG_POSITION = 6'd2,
      REG_HALF_MOVE = 6'd3,
      REG_BOARD_0 = 6'd8,
      REG_BOARD_1 = 6'd9,
      REG_BOARD_2 = 6'd10,
      REG_BOARD_3 = 6'd11,
      REG_BOARD_4 = 6'd12,
      REG_BOARD_5 = 6'd13,
      REG_BOARD_6 = 6'd14,
      REG_BOARD_7 = 6'd15,
      REG_TT_ENTRY_LO = 6'd16,
      REG_TT_ENTRY_HI = 6'd17,
      REG_TT_CMD = 6'd18, // write only
      REG_GEN_STATUS = 6'd32,
      REG_MOVE_COUNT = 6'd33,
      REG_MOVE_EVAL = 6'd34,
      REG_TT_RESULT_LO = 6'd36,
      REG_TT_RESULT_HI = 6'd37
   } reg_addr_e;

   typedef enum logic [1:0] {
      TT_EXACT = 2'd0,
      TT_LOWER = 2'd1,
      TT_UPPER = 2'd2
   } tt_flag_e;

   typedef enum logic {
      WB_IDLE = 1'b0,
      WB_ACK = 1'b1
   } wb_state_e;

endpackage

//--- logic/reg_access_if.sv
/* one decoded register access, valid for a single cycle per bus transfer */
`timescale 1ns/1ps

interface reg_access_if;

   logic valid;
   logic write;
   engine_ctrl_pkg::reg_addr_e addr;
   logic [engine_ctrl_pkg::DATA_WIDTH-1:0] wdata;
   logic [engine_ctrl_pkg::SEL_WIDTH-1:0] sel;

   modport port (
      output valid, write, addr, wdata, sel
   );

   // register writers
   modport regs (
      input valid, write, addr, wdata, sel
   );

   modport read (
      input valid, addr
   );

endinterface

//--- logic/wb_slave_port.sv
/* Wishbone classic slave, one wait cycle per transfer
   issues a single-cycle access on the register interface and acks the next cycle */
`timescale 1ns/1ps

module wb_slave_port (
   input  logic clk,
   input  logic reset,
   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  logic [engine_ctrl_pkg::ADDR_WIDTH-1:0] wb_adr,
   input  logic [engine_ctrl_pkg::DATA_WIDTH-1:0] wb_dat_w,
   input  logic [engine_ctrl_pkg::SEL_WIDTH-1:0] wb_sel,
   output logic wb_ack,
   reg_access_if.port acc
);

   engine_ctrl_pkg::wb_state_e state;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= engine_ctrl_pkg::WB_IDLE;
      else if (state == engine_ctrl_pkg::WB_ACK)
         state <= engine_ctrl_pkg::WB_IDLE; // one ack cycle only
      else if (wb_cyc && wb_stb)
         state <= engine_ctrl_pkg::WB_ACK;
   end

   assign wb_ack = (state == engine_ctrl_pkg::WB_ACK);

   // held stb during ack is not a new access
   assign acc.valid = wb_cyc && wb_stb && (state == engine_ctrl_pkg::WB_IDLE);
   assign acc.write = wb_we;
   assign acc.addr = engine_ctrl_pkg::reg_addr_e'(wb_adr);
   assign acc.wdata = wb_dat_w;
   assign acc.sel = wb_sel;

endmodule

//--- logic/position_regs.sv
/* move generator request registers: command, move index, position, half move, board
   written from the register interface, outputs drive the generator and readback */
`timescale 1ns/1ps

module position_regs (
   input  logic clk,
   input  logic reset,
   reg_access_if.regs acc,
   output logic new_board_valid,
   output logic clear_moves,
   output logic soft_reset,
   output logic [engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index,
   output logic white_to_move,
   output logic [3:0] castle_mask,
   output logic [3:0] en_passant_col,
   output logic [engine_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move,
   output logic [engine_ctrl_pkg::BOARD_WIDTH-1:0] board
);

   logic [$clog2(engine_ctrl_pkg::BOARD_WORDS)-1:0] word;
   logic wr_en;

   assign word = acc.addr[$clog2(engine_ctrl_pkg::BOARD_WORDS)-1:0];
   assign wr_en = acc.valid && acc.write;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         new_board_valid <= 1'b0;
         clear_moves <= 1'b0;
         soft_reset <= 1'b0;
         move_index <= '0;
         white_to_move <= 1'b0;
         castle_mask <= '0;
         en_passant_col <= '0;
         half_move <= '0;
         board <= '0;
      end
      else if (wr_en)
      begin
         case (acc.addr)
            engine_ctrl_pkg::REG_CMD:
            begin
               // level bits that the host clears with another write
               new_board_valid <= acc.wdata[engine_ctrl_pkg::CMD_NEW_BOARD_BIT];
               clear_moves <= acc.wdata[engine_ctrl_pkg::CMD_CLEAR_MOVES_BIT];
               soft_reset <= acc.wdata[engine_ctrl_pkg::CMD_SOFT_RESET_BIT];
            end
            engine_ctrl_pkg::REG_MOVE_INDEX:
               move_index <= acc.wdata[engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0];
            engine_ctrl_pkg::REG_POSITION:
            begin
               en_passant_col <= acc.wdata[3:0];
               castle_mask <= acc.wdata[engine_ctrl_pkg::POS_CASTLE_LSB +: 4];
               white_to_move <= acc.wdata[engine_ctrl_pkg::POS_WHITE_BIT];
            end
            engine_ctrl_pkg::REG_HALF_MOVE:
               half_move <= acc.wdata[engine_ctrl_pkg::HALF_MOVE_WIDTH-1:0];
            engine_ctrl_pkg::REG_BOARD_0, engine_ctrl_pkg::REG_BOARD_1,
            engine_ctrl_pkg::REG_BOARD_2, engine_ctrl_pkg::REG_BOARD_3,
            engine_ctrl_pkg::REG_BOARD_4, engine_ctrl_pkg::REG_BOARD_5,
            engine_ctrl_pkg::REG_BOARD_6, engine_ctrl_pkg::REG_BOARD_7:
            begin
               // only the selected bytes of the word change
               for (int b = 0; b < engine_ctrl_pkg::SEL_WIDTH; b++)
               begin
                  if (acc.sel[b])
                     board[engine_ctrl_pkg::DATA_WIDTH * word + 8 * b +: 8] <=
                        acc.wdata[8 * b +: 8];
               end
            end
            default:
            begin
            end
         endcase
      end
   end

endmodule

//--- logic/trans_cmd_regs.sv
/* transposition table entry staging and self-clearing command pulses
   a command write fires its pulses for the one cycle that lines up with ack */
`timescale 1ns/1ps

module trans_cmd_regs (
   input  logic clk,
   input  logic reset,
   reg_access_if.regs acc,
   output logic [engine_ctrl_pkg::EVAL_WIDTH-1:0] tt_eval,
   output logic [engine_ctrl_pkg::DEPTH_WIDTH-1:0] tt_depth,
   output logic [engine_ctrl_pkg::NODES_WIDTH-1:0] tt_nodes,
   output engine_ctrl_pkg::tt_flag_e tt_flag,
   output logic tt_capture,
   output logic tt_lookup,
   output logic tt_store,
   output logic tt_hash_only,
   output logic tt_clear
);

   logic wr_en;

   assign wr_en = acc.valid && acc.write;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tt_eval <= '0;
         tt_depth <= '0;
         tt_nodes <= '0;
         tt_flag <= engine_ctrl_pkg::TT_EXACT;
         tt_capture <= 1'b0;
         tt_lookup <= 1'b0;
         tt_store <= 1'b0;
         tt_hash_only <= 1'b0;
         tt_clear <= 1'b0;
      end
      else
      begin
         tt_lookup <= 1'b0; // pulses drop back unless rewritten below
         tt_store <= 1'b0;
         tt_hash_only <= 1'b0;
         tt_clear <= 1'b0;
         if (wr_en)
         begin
            case (acc.addr)
               engine_ctrl_pkg::REG_TT_ENTRY_LO:
               begin
                  tt_eval <= acc.wdata[engine_ctrl_pkg::EVAL_WIDTH-1:0];
                  tt_depth <= acc.wdata[engine_ctrl_pkg::EVAL_WIDTH +:
                                        engine_ctrl_pkg::DEPTH_WIDTH];
               end
               engine_ctrl_pkg::REG_TT_ENTRY_HI:
               begin
                  tt_nodes <= acc.wdata[engine_ctrl_pkg::NODES_WIDTH-1:0];
                  tt_flag <= engine_ctrl_pkg::tt_flag_e'(
                     acc.wdata[engine_ctrl_pkg::ENTRY_FLAG_LSB +: 2]);
                  tt_capture <= acc.wdata[engine_ctrl_pkg::ENTRY_CAPTURE_BIT];
               end
               engine_ctrl_pkg::REG_TT_CMD:
               begin
                  tt_lookup <= acc.wdata[engine_ctrl_pkg::TT_LOOKUP_BIT];
                  tt_store <= acc.wdata[engine_ctrl_pkg::TT_STORE_BIT];
                  tt_hash_only <= acc.wdata[engine_ctrl_pkg::TT_HASH_ONLY_BIT];
                  tt_clear <= acc.wdata[engine_ctrl_pkg::TT_CLEAR_BIT];
               end
               default:
               begin
               end
            endcase
         end
      end
   end

endmodule

//--- logic/status_readback.sv
/* registered read mux over the control registers and engine status
   loads on every access so the word is valid alongside ack */
`timescale 1ns/1ps

module status_readback (
   input  logic clk,
   input  logic reset,
   reg_access_if.read acc,
   input  logic new_board_valid,
   input  logic clear_moves,
   input  logic soft_reset,
   input  logic [engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index,
   input  logic white_to_move,
   input  logic [3:0] castle_mask,
   input  logic [3:0] en_passant_col,
   input  logic [engine_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move,
   input  logic [engine_ctrl_pkg::BOARD_WIDTH-1:0] board,
   input  logic [engine_ctrl_pkg::EVAL_WIDTH-1:0] tt_eval,
   input  logic [engine_ctrl_pkg::DEPTH_WIDTH-1:0] tt_depth,
   input  logic [engine_ctrl_pkg::NODES_WIDTH-1:0] tt_nodes,
   input  engine_ctrl_pkg::tt_flag_e tt_flag,
   input  logic tt_capture,
   input  logic moves_ready,
   input  logic move_ready,
   input  logic gen_idle,
   input  logic tt_idle,
   input  logic tt_entry_valid,
   input  logic [engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_count,
   input  logic [engine_ctrl_pkg::EVAL_WIDTH-1:0] move_eval,
   input  logic [engine_ctrl_pkg::EVAL_WIDTH-1:0] tt_eval_in,
   input  logic [engine_ctrl_pkg::DEPTH_WIDTH-1:0] tt_depth_in,
   input  logic [engine_ctrl_pkg::NODES_WIDTH-1:0] tt_nodes_in,
   input  engine_ctrl_pkg::tt_flag_e tt_flag_in,
   input  logic tt_capture_in,
   output logic [engine_ctrl_pkg::DATA_WIDTH-1:0] wb_dat_r
);

   logic [engine_ctrl_pkg::DATA_WIDTH-1:0] rd_word;

   always_comb
   begin
      rd_word = '0; // unmapped and write-only addresses
      case (acc.addr)
         engine_ctrl_pkg::REG_CMD:
         begin
            rd_word[engine_ctrl_pkg::CMD_NEW_BOARD_BIT] = new_board_valid;
            rd_word[engine_ctrl_pkg::CMD_CLEAR_MOVES_BIT] = clear_moves;
            rd_word[engine_ctrl_pkg::CMD_SOFT_RESET_BIT] = soft_reset;
         end
         engine_ctrl_pkg::REG_MOVE_INDEX:
            rd_word[engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] = move_index;
         engine_ctrl_pkg::REG_POSITION:
         begin
            rd_word[3:0] = en_passant_col;
            rd_word[engine_ctrl_pkg::POS_CASTLE_LSB +: 4] = castle_mask;
            rd_word[engine_ctrl_pkg::POS_WHITE_BIT] = white_to_move;
         end
         engine_ctrl_pkg::REG_HALF_MOVE:
            rd_word[engine_ctrl_pkg::HALF_MOVE_WIDTH-1:0] = half_move;
         engine_ctrl_pkg::REG_BOARD_0, engine_ctrl_pkg::REG_BOARD_1,
         engine_ctrl_pkg::REG_BOARD_2, engine_ctrl_pkg::REG_BOARD_3,
         engine_ctrl_pkg::REG_BOARD_4, engine_ctrl_pkg::REG_BOARD_5,
         engine_ctrl_pkg::REG_BOARD_6, engine_ctrl_pkg::REG_BOARD_7:
            rd_word = board[engine_ctrl_pkg::DATA_WIDTH * acc.addr[2:0] +:
                            engine_ctrl_pkg::DATA_WIDTH];
         engine_ctrl_pkg::REG_TT_ENTRY_LO:
            rd_word = {tt_depth, tt_eval};
         engine_ctrl_pkg::REG_TT_ENTRY_HI:
            rd_word = {tt_capture, 1'b0, tt_flag, tt_nodes};
         engine_ctrl_pkg::REG_GEN_STATUS:
            rd_word[4:0] = {tt_entry_valid, tt_idle, gen_idle, move_ready, moves_ready};
         engine_ctrl_pkg::REG_MOVE_COUNT:
            rd_word[engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] = move_count;
         engine_ctrl_pkg::REG_MOVE_EVAL:
            rd_word = {{(engine_ctrl_pkg::DATA_WIDTH - engine_ctrl_pkg::EVAL_WIDTH)
                        {move_eval[engine_ctrl_pkg::EVAL_WIDTH-1]}}, move_eval};
         engine_ctrl_pkg::REG_TT_RESULT_LO:
            rd_word = {tt_depth_in, tt_eval_in};
         engine_ctrl_pkg::REG_TT_RESULT_HI:
            rd_word = {tt_capture_in, 1'b0, tt_flag_in, tt_nodes_in};
         default:
         begin
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         wb_dat_r <= '0;
      else if (acc.valid)
         wb_dat_r <= rd_word; // holds between accesses
   end

endmodule

//--- logic/engine_ctrl_top.sv
/* engine control register block on a 32-bit Wishbone classic bus
   host loads the root position and drives the transposition table through it */
`timescale 1ns/1ps

module engine_ctrl_top (
   input  logic clk,
   input  logic reset,
   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  logic [engine_ctrl_pkg::ADDR_WIDTH-1:0] wb_adr,
   input  logic [engine_ctrl_pkg::DATA_WIDTH-1:0] wb_dat_w,
   input  logic [engine_ctrl_pkg::SEL_WIDTH-1:0] wb_sel,
   output logic [engine_ctrl_pkg::DATA_WIDTH-1:0] wb_dat_r,
   output logic wb_ack,
   output logic new_board_valid,
   output logic clear_moves,
   output logic soft_reset,
   output logic [engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_index,
   output logic white_to_move,
   output logic [3:0] castle_mask,
   output logic [3:0] en_passant_col,
   output logic [engine_ctrl_pkg::HALF_MOVE_WIDTH-1:0] half_move,
   output logic [engine_ctrl_pkg::BOARD_WIDTH-1:0] board,
   output logic [engine_ctrl_pkg::EVAL_WIDTH-1:0] tt_eval,
   output logic [engine_ctrl_pkg::DEPTH_WIDTH-1:0] tt_depth,
   output logic [engine_ctrl_pkg::NODES_WIDTH-1:0] tt_nodes,
   output engine_ctrl_pkg::tt_flag_e tt_flag,
   output logic tt_capture,
   output logic tt_lookup,
   output logic tt_store,
   output logic tt_hash_only,
   output logic tt_clear,
   input  logic moves_ready,
   input  logic move_ready,
   input  logic gen_idle,
   input  logic tt_idle,
   input  logic tt_entry_valid,
   input  logic [engine_ctrl_pkg::MOVE_INDEX_WIDTH-1:0] move_count,
   input  logic [engine_ctrl_pkg::EVAL_WIDTH-1:0] move_eval,
   input  logic [engine_ctrl_pkg::EVAL_WIDTH-1:0] tt_eval_in,
   input  logic [engine_ctrl_pkg::DEPTH_WIDTH-1:0] tt_depth_in,
   input  logic [engine_ctrl_pkg::NODES_WIDTH-1:0] tt_nodes_in,
   input  engine_ctrl_pkg::tt_flag_e tt_flag_in,
   input  logic tt_capture_in
);

   reg_access_if acc ();

   wb_slave_port wb_slave_port_i (
      .clk(clk), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
      .wb_ack(wb_ack), .acc(acc.port)
   );

   position_regs position_regs_i (
      .clk(clk), .reset(reset), .acc(acc.regs),
      .new_board_valid(new_board_valid), .clear_moves(clear_moves),
      .soft_reset(soft_reset), .move_index(move_index),
      .white_to_move(white_to_move), .castle_mask(castle_mask),
      .en_passant_col(en_passant_col), .half_move(half_move), .board(board)
   );

   trans_cmd_regs trans_cmd_regs_i (
      .clk(clk), .reset(reset), .acc(acc.regs),
      .tt_eval(tt_eval), .tt_depth(tt_depth), .tt_nodes(tt_nodes),
      .tt_flag(tt_flag), .tt_capture(tt_capture),
      .tt_lookup(tt_lookup), .tt_store(tt_store),
      .tt_hash_only(tt_hash_only), .tt_clear(tt_clear)
   );

   // readback sees the register outputs plus live engine status
   status_readback status_readback_i (
      .clk(clk), .reset(reset), .acc(acc.read),
      .new_board_valid(new_board_valid), .clear_moves(clear_moves),
      .soft_reset(soft_reset), .move_index(move_index),
      .white_to_move(white_to_move), .castle_mask(castle_mask),
      .en_passant_col(en_passant_col), .half_move(half_move), .board(board),
      .tt_eval(tt_eval), .tt_depth(tt_depth), .tt_nodes(tt_nodes),
      .tt_flag(tt_flag), .tt_capture(tt_capture),
      .moves_ready(moves_ready), .move_ready(move_ready), .gen_idle(gen_idle),
      .tt_idle(tt_idle), .tt_entry_valid(tt_entry_valid),
      .move_count(move_count), .move_eval(move_eval),
      .tt_eval_in(tt_eval_in), .tt_depth_in(tt_depth_in),
      .tt_nodes_in(tt_nodes_in), .tt_flag_in(tt_flag_in),
      .tt_capture_in(tt_capture_in),
      .wb_dat_r(wb_dat_r)
   );

endmodule

//--- tb/ctrl_model.svh
/* register model for the engine control testbench, included inside the testbench module
   holds the LFSR, the shadow registers and the expected readback of every address */
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

logic [31:0] lfsr_state = 32'h4037;
logic [31:0] shadow [0:63]; // one word per address and read-only ones stay 0

// fibonacci lfsr with taps 32 22 2 1 stepped once per bit drawn
function automatic logic [31:0] draw(input int nbits);
   logic [31:0] value;
   logic fb;
   value = '0;
   for (int k = 0; k < nbits; k++)
   begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = {value[30:0], fb};
   end
   return value;
endfunction

// bits that a write to this address keeps
function automatic logic [31:0] write_mask(input logic [5:0] adr, input logic [3:0] sel);
   case (adr)
      6'd0: return 32'h8000_0003; // soft reset, clear moves, new board
      6'd1: return 32'h0000_00ff;
      6'd2: return 32'h0000_01ff;
      6'd3: return 32'h0000_007f;
      6'd16: return 32'hffff_ffff;
      6'd17: return 32'hbfff_ffff; // bit 30 unused
      default:
         if (adr >= 6'd8 && adr <= 6'd15)
            return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
         else
            return 32'h0;
   endcase
endfunction

function automatic void apply_write(input logic [5:0] adr, input logic [31:0] data,
                                    input logic [3:0] sel);
   logic [31:0] mask;
   mask = write_mask(adr, sel);
   shadow[adr] = (shadow[adr] & ~mask) | (data & mask);
endfunction

function automatic logic [31:0] expected_read(input logic [5:0] adr);
   case (adr)
      6'd32: return {27'd0, tt_entry_valid, tt_idle, gen_idle, move_ready, moves_ready};
      6'd33: return {24'd0, move_count};
      6'd34: return {{8{move_eval[23]}}, move_eval};
      6'd36: return {tt_depth_in, tt_eval_in};
      6'd37: return {tt_capture_in, 1'b0, tt_flag_in, tt_nodes_in};
      default: return shadow[adr];
   endcase
endfunction

`endif

//--- tb/engine_ctrl_tb.sv
/* testbench for the engine control register block
   random Wishbone accesses in five phases, checked against the register model */
`timescale 1ns/1ps

module engine_ctrl_tb;

   localparam int ACCESSES = 500;
   localparam int CYCLE_NS = 100;

   logic clk;
   logic reset;
   logic wb_cyc, wb_stb, wb_we;
   logic [5:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic [3:0] wb_sel;
   logic [31:0] wb_dat_r;
   logic wb_ack;
   logic new_board_valid, clear_moves, soft_reset;
   logic [7:0] move_index;
   logic white_to_move;
   logic [3:0] castle_mask, en_passant_col;
   logic [6:0] half_move;
   logic [255:0] board;
   logic [23:0] tt_eval;
   logic [7:0] tt_depth;
   logic [27:0] tt_nodes;
   engine_ctrl_pkg::tt_flag_e tt_flag;
   logic tt_capture, tt_lookup, tt_store, tt_hash_only, tt_clear;
   logic moves_ready, move_ready, gen_idle, tt_idle, tt_entry_valid;
   logic [7:0] move_count;
   logic [23:0] move_eval, tt_eval_in;
   logic [7:0] tt_depth_in;
   logic [27:0] tt_nodes_in;
   engine_ctrl_pkg::tt_flag_e tt_flag_in;
   logic tt_capture_in;
   logic [3:0] pulses;
   int check_count = 0;
   int error_count = 0;

   `include "ctrl_model.svh"

   assign pulses = {tt_clear, tt_hash_only, tt_store, tt_lookup};

   engine_ctrl_top engine_ctrl_top_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CYCLE_NS / 2) clk = ~clk;
   end

   task automatic compare_value(input string name, input logic [255:0] got,
                                input logic [255:0] exp);
      check_count++;
      assert (got === exp)
      else
      begin
         $display("MISMATCH %s got %0h expected %0h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic require(input logic cond, input string what);
      check_count++;
      assert (cond)
      else
      begin
         $display("ERROR %s", what);
         error_count++;
      end
   endtask

   task automatic verify_ports;
      compare_value("{soft_reset,clear_moves,new_board_valid}",
                    {soft_reset, clear_moves, new_board_valid},
                    {shadow[0][31], shadow[0][1], shadow[0][0]});
      compare_value("move_index", move_index, shadow[1][7:0]);
      compare_value("{white_to_move,castle_mask,en_passant_col}",
                    {white_to_move, castle_mask, en_passant_col}, shadow[2][8:0]);
      compare_value("half_move", half_move, shadow[3][6:0]);
      compare_value("board", board, {shadow[15], shadow[14], shadow[13], shadow[12],
                                     shadow[11], shadow[10], shadow[9], shadow[8]});
      compare_value("{tt_depth,tt_eval}", {tt_depth, tt_eval}, shadow[16]);
      compare_value("{tt_capture,tt_flag,tt_nodes}", {tt_capture, tt_flag, tt_nodes},
                    {shadow[17][31], shadow[17][29:0]});
   endtask

   // engine status held steady across the following access
   task automatic drive_status;
      @(posedge clk);
      moves_ready <= 1'(draw(1));
      move_ready <= 1'(draw(1));
      gen_idle <= 1'(draw(1));
      tt_idle <= 1'(draw(1));
      tt_entry_valid <= 1'(draw(1));
      move_count <= 8'(draw(8));
      move_eval <= 24'(draw(24));
      tt_eval_in <= 24'(draw(24));
      tt_depth_in <= 8'(draw(8));
      tt_nodes_in <= 28'(draw(28));
      tt_flag_in <= engine_ctrl_pkg::tt_flag_e'(2'(draw(2) % 3));
      tt_capture_in <= 1'(draw(1));
   endtask

   task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] data,
                             input logic [3:0] sel);
      int waited;
      logic [31:0] expected;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= we;
      wb_adr <= adr;
      wb_dat_w <= data;
      wb_sel <= sel;
      waited = 0;
      @(negedge clk);
      while (!wb_ack && waited < 8)
      begin
         @(negedge clk);
         waited++;
      end
      require(wb_ack, $sformatf("no ack from address %0h within 8 cycles", adr));
      require(waited == 1, $sformatf("ack came %0d cycles after stb instead of 1", waited));
      expected = expected_read(adr);
      if (we)
         apply_write(adr, data, sel);
      else
         compare_value($sformatf("wb_dat_r@%0h", adr), wb_dat_r, expected);
      verify_ports();
      compare_value("{tt_clear,tt_hash_only,tt_store,tt_lookup}", pulses,
                    (we && adr == 6'd18) ? data[3:0] : 4'h0); // pulses only in ack cycle
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      @(negedge clk);
      require(!wb_ack, "ack stayed high for more than one cycle");
      compare_value("{tt_clear,tt_hash_only,tt_store,tt_lookup}", pulses, 4'h0);
   endtask

   initial
   begin
      logic [5:0] adr;
      logic we;
      for (int a = 0; a < 64; a++)
         shadow[a] = '0;
      reset = 1'b1;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w, wb_sel} = '0;
      {moves_ready, move_ready, gen_idle, tt_idle, tt_entry_valid} = '0;
      {move_count, move_eval, tt_eval_in, tt_depth_in, tt_nodes_in, tt_capture_in} = '0;
      tt_flag_in = engine_ctrl_pkg::TT_EXACT;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      verify_ports();
      compare_value("{tt_clear,tt_hash_only,tt_store,tt_lookup}", pulses, 4'h0);
      require(!wb_ack, "ack high after reset");
      // control regs, board words, table regs, the whole map, then status reads
      for (int i = 0; i < ACCESSES; i++)
      begin
         case (i / 100)
            0: adr = 6'(draw(2));
            1: adr = 6'd8 + 6'(draw(3));
            2: adr = 6'd16 + 6'(draw(2));
            3: adr = 6'(draw(6));
            default: adr = 6'd32 + 6'(draw(3));
         endcase
         if (i / 100 == 4)
            we = 1'b0;
         else if (i / 100 == 3)
            we = (draw(2) == 32'd0);
         else
            we = 1'(draw(1));
         drive_status();
         bus_access(we, adr, draw(32), 4'(draw(4)));
      end
      $display("checks %0d errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   initial
   begin
      #((ACCESSES * 4 + 50) * CYCLE_NS);
      $display("timeout, the %0d accesses did not finish in time", ACCESSES);
      $display("Test failed");
      $finish;
   end

endmodule

//--- tb.f
+incdir+tb
logic/engine_ctrl_pkg.sv
logic/reg_access_if.sv
logic/wb_slave_port.sv
logic/position_regs.sv
logic/trans_cmd_regs.sv
logic/status_readback.sv
logic/engine_ctrl_top.sv
tb/engine_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the engine control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module engine_ctrl_tb \
   -o engine_ctrl_sim \
   && ./obj_dir/engine_ctrl_sim | tee sim.log \
   || { echo "build or simulation error"; exit 1; }
grep -q "Test completed successfully" sim.log && exit 0 || exit 1
